// ==== hdl/isaPkg.sv ====
package isaPkg;

    localparam int opcodeW = 16;  // Instruction width
    localparam int flagsW  = 4;   // Flag register width

    // Field positions inside the opcode
    localparam int s1Lsb      = 9;   // s1 is opcode[11:9]
    localparam int destALsb   = 0;   // A type destination in [2:0]
    localparam int destSiLsb  = 4;   // SI type destination in [6:4]
    localparam int spSubLsb   = 7;   // SP type subtype in [8:7]
    localparam int flagSelLsb = 8;   // Flag index in [9:8]
    localparam int flagValBit = 10;  // Flag value to test or write
    localparam int flagOpBit  = 11;  // Set for FLS/FLC

    typedef enum logic [2:0] {
        CLS_A,
        CLS_I,
        CLS_J,
        CLS_SI,
        CLS_F,
        CLS_SP
    } instrClass_t;

    // SP type subtypes still supported
    localparam logic [1:0] SP_PUSH = 2'b00;
    localparam logic [1:0] SP_POP  = 2'b01;

    // Source field s1, codes 0 to 3 name a register
    typedef logic [2:0] readMode_t;

    localparam readMode_t RM_IMM  = 3'd4;  // Operand follows the instruction
    localparam readMode_t RM_BAD5 = 3'd5;
    localparam readMode_t RM_ADDR = 3'd6;  // Operand at (A)
    localparam readMode_t RM_BAD7 = 3'd7;

    typedef logic [2:0] dest_t;

    localparam dest_t DEST_ZERO = 3'd0;  // SP for I type, flags for POP
    localparam dest_t DEST_A    = 3'd1;
    localparam dest_t DEST_B    = 3'd2;
    localparam dest_t DEST_C    = 3'd3;
    localparam dest_t DEST_ADR  = 3'd4;  // Memory at (A)
    localparam dest_t DEST_BAD5 = 3'd5;
    localparam dest_t DEST_BAD6 = 3'd6;

endpackage

// ==== hdl/ctrlPkg.sv ====
package ctrlPkg;

    import isaPkg::*;

    typedef enum logic [5:0] {
        START    = 6'd0,
        FETCH    = 6'd1,
        ATYPE    = 6'd2,
        ITYPE    = 6'd3,
        JTYPE    = 6'd4,
        SITYPE   = 6'd5,
        JFGINSTR = 6'd6,   // Taken JFS/JFC
        PUSH1    = 6'd8,
        PUSH2    = 6'd9,
        POP1     = 6'd10,
        POP2     = 6'd11,
        RIMMED   = 6'd20,  // Operand read at (PC)
        RADDRESS = 6'd21,  // Operand read at (A)
        HALT     = 6'd63   // Trap for invalid instructions
    } state_t;

    typedef enum logic [1:0] {
        MEM_PC  = 2'd0,
        MEM_A   = 2'd1,
        MEM_SP  = 2'd2,
        MEM_ALU = 2'd3
    } memSrc_t;

    // Codes 0 to 3 select a register
    typedef logic [3:0] aluASrc_t;

    localparam aluASrc_t ALUA_PC  = 4'd4;
    localparam aluASrc_t ALUA_SP  = 4'd5;
    localparam aluASrc_t ALUA_MEM = 4'd6;

    // Codes 0 to 3 select a register
    typedef logic [3:0] aluBSrc_t;

    localparam aluBSrc_t ALUB_ONE  = 4'd4;
    localparam aluBSrc_t ALUB_OP   = 4'd5;  // Immediate from the opcode
    localparam aluBSrc_t ALUB_ADDR = 4'd6;  // Jump offset from the opcode
    localparam aluBSrc_t ALUB_ZERO = 4'd7;

    typedef enum logic [1:0] {
        FSRC_ALU    = 2'd0,
        FSRC_INSTR  = 2'd1,
        FSRC_ALUOUT = 2'd2
    } flagSrc_t;

    localparam logic [3:0] ALU_ADD = 4'd0;
    localparam logic [3:0] ALU_SUB = 4'd2;
    localparam logic [3:0] ALU_JMP = 4'd6;

    typedef struct packed {
        memSrc_t             memAddr;
        logic                re;
        logic                we;
        logic                readStack;   // Address selects the stack segment
        logic                saveOpcode;
        logic                saveMem;     // Load the operand register
        logic                enPC;
        logic [3:0]          aluFunc;
        aluASrc_t            aluA;
        aluBSrc_t            aluB;
        logic                enA;
        logic                enB;
        logic                enC;
        logic                enSP;
        logic                enF;
        flagSrc_t            sourceF;
        logic [flagsW-1:0]   inF;         // Flag value for FLS/FLC
    } ctrlWord_t;

    typedef struct packed {
        state_t              mainState;   // State after fetch and operand read
        readMode_t           readMode;
        dest_t               dest;
        logic                isFlagOp;
        logic [flagsW-1:0]   newFlags;
    } decoded_t;

endpackage

// ==== hdl/instrDecoder.sv ====
module instrDecoder
    import isaPkg::*, ctrlPkg::*;
(
    input  logic [opcodeW-1:0] opcode,  // Current instruction
    input  logic [flagsW-1:0]  flags,   // Current flag register
    output decoded_t           dec
);

    instrClass_t cls;
    readMode_t   srcMode;
    dest_t       dstSel;
    logic [1:0]  spSub;
    logic [1:0]  flagSel;
    logic        usesDest;
    logic        readsOperand;
    logic        badDest;
    logic        badRead;

    assign srcMode = opcode[s1Lsb +: 3];
    assign spSub   = opcode[spSubLsb +: 2];
    assign flagSel = opcode[flagSelLsb +: 2];

    always_comb begin  // Class from the top nibble
        casez (opcode[opcodeW-1 -: 4])
            4'b0000: cls = CLS_A;
            4'b0001: cls = CLS_SI;
            4'b0010: cls = CLS_F;
            4'b0011: cls = CLS_SP;
            4'b01??: cls = CLS_I;
            default: cls = CLS_J;  // 1xxx
        endcase
    end

    always_comb begin  // Destination field depends on class
        case (cls)
            CLS_A:   dstSel = opcode[destALsb +: 3];
            CLS_SI:  dstSel = opcode[destSiLsb +: 3];
            default: dstSel = opcode[s1Lsb +: 3];  // I and POP share s1
        endcase
    end

    assign usesDest = (cls == CLS_A) || (cls == CLS_I) || (cls == CLS_SI)
                      || (cls == CLS_SP && spSub == SP_POP);
    assign readsOperand = (cls == CLS_A) || (cls == CLS_I) || (cls == CLS_SI)
                          || (cls == CLS_SP && spSub == SP_PUSH);

    assign badDest = usesDest && (dstSel == DEST_BAD5 || dstSel == DEST_BAD6);
    assign badRead = readsOperand && (srcMode == RM_BAD5 || srcMode == RM_BAD7);

    always_comb begin
        dec.readMode  = srcMode;
        dec.dest      = dstSel;
        dec.isFlagOp  = 1'b0;
        dec.newFlags  = flags;
        dec.newFlags[flagSel] = opcode[flagValBit];  // FLS sets, FLC clears
        case (cls)
            CLS_A:  dec.mainState = ATYPE;
            CLS_I:  dec.mainState = ITYPE;
            CLS_J:  dec.mainState = JTYPE;
            CLS_SI: dec.mainState = SITYPE;
            CLS_F: begin
                if (opcode[flagOpBit]) begin
                    dec.mainState = FETCH;  // Done within fetch
                    dec.isFlagOp  = 1'b1;
                end else if (flags[flagSel] == opcode[flagValBit]) begin
                    dec.mainState = JFGINSTR;
                end else begin
                    dec.mainState = FETCH;  // Condition false
                end
            end
            CLS_SP: begin
                case (spSub)
                    SP_PUSH: dec.mainState = PUSH1;
                    SP_POP:  dec.mainState = POP1;
                    default: dec.mainState = HALT;  // SVPC and RET codes
                endcase
            end
            default: dec.mainState = HALT;
        endcase
        if (badDest || badRead) begin
            dec.mainState = HALT;  // Dropped addressing modes trap
        end
    end

endmodule

// ==== hdl/stateSequencer.sv ====
module stateSequencer
    import isaPkg::*, ctrlPkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               stall,   // Hold the current state
    input  logic [opcodeW-1:0] opcode,
    input  decoded_t           dec,
    output state_t             state
);

    state_t nextState;
    logic   needsOperand;
    logic   skipRead;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= START;
        end else if (!stall) begin
            state <= nextState;
        end
    end

    // Classes that take a source operand through s1
    assign needsOperand = (dec.mainState == ATYPE) || (dec.mainState == ITYPE)
                          || (dec.mainState == SITYPE) || (dec.mainState == PUSH1);

    // I type with bit 8 and class bits 11 needs no operand
    assign skipRead = (dec.mainState == ITYPE) && opcode[8]
                      && (opcode[13:12] == 2'b11);

    always_comb begin
        nextState = HALT;  // Unknown states trap
        case (state)
            START: nextState = FETCH;
            FETCH: begin
                if (needsOperand && !skipRead && dec.readMode[2]) begin
                    case (dec.readMode)
                        RM_IMM:  nextState = RIMMED;
                        RM_ADDR: nextState = RADDRESS;
                        default: nextState = HALT;
                    endcase
                end else begin
                    nextState = dec.mainState;
                end
            end
            RIMMED, RADDRESS: begin
                nextState = dec.mainState;  // Operand ready, run the instruction
            end
            PUSH1: nextState = PUSH2;
            POP1:  nextState = POP2;
            ATYPE, ITYPE, SITYPE, JTYPE, JFGINSTR, PUSH2, POP2: begin
                nextState = FETCH;
            end
            default: nextState = HALT;  // HALT stays until reset
        endcase
    end

endmodule

// ==== hdl/controlDecoder.sv ====
module controlDecoder
    import isaPkg::*, ctrlPkg::*;
(
    input  state_t             state,
    input  logic [opcodeW-1:0] opcode,
    input  decoded_t           dec,
    output ctrlWord_t          ctrl
);

    aluASrc_t srcA;

    // Register named by s1, or the operand register for memory modes
    assign srcA = dec.readMode[2] ? ALUA_MEM : {2'b00, dec.readMode[1:0]};

    // Register and (A) destinations, code 0 is handled by the caller
    function automatic ctrlWord_t applyDest(ctrlWord_t cwIn, dest_t d);
        ctrlWord_t cw;
        cw = cwIn;
        case (d)
            DEST_A: cw.enA = 1'b1;
            DEST_B: cw.enB = 1'b1;
            DEST_C: cw.enC = 1'b1;
            DEST_ADR: begin
                cw.we      = 1'b1;  // Result written to (A)
                cw.memAddr = MEM_A;
            end
            default: begin
            end
        endcase
        return cw;
    endfunction

    // PC + 1 through the ALU
    function automatic ctrlWord_t incPc(ctrlWord_t cwIn);
        ctrlWord_t cw;
        cw         = cwIn;
        cw.aluFunc = ALU_ADD;
        cw.aluA    = ALUA_PC;
        cw.aluB    = ALUB_ONE;
        cw.enPC    = 1'b1;
        return cw;
    endfunction

    always_comb begin
        ctrl = '0;
        case (state)
            FETCH: begin
                ctrl.memAddr    = MEM_PC;
                ctrl.re         = 1'b1;
                ctrl.saveOpcode = 1'b1;
                ctrl            = incPc(ctrl);
                if (dec.isFlagOp) begin
                    ctrl.enF     = 1'b1;
                    ctrl.sourceF = FSRC_INSTR;
                    ctrl.inF     = dec.newFlags;
                end
            end
            ATYPE: begin
                ctrl.aluA    = srcA;
                ctrl.aluB    = {2'b00, opcode[4:3]};
                ctrl.aluFunc = opcode[8:5];  // Function taken from the opcode
                ctrl.enF     = 1'b1;
                ctrl.sourceF = FSRC_ALU;
                ctrl         = applyDest(ctrl, dec.dest);
            end
            ITYPE: begin
                // s1 is source and destination, code 0 means SP
                ctrl.aluA    = (dec.dest == DEST_ZERO) ? ALUA_SP : srcA;
                ctrl.aluB    = ALUB_OP;
                ctrl.aluFunc = {opcode[8], opcode[8], opcode[13:12]};
                ctrl.enF     = 1'b1;
                ctrl.sourceF = FSRC_ALU;
                if (dec.dest == DEST_ZERO) begin
                    ctrl.enSP = 1'b1;
                end else begin
                    ctrl = applyDest(ctrl, dec.dest);
                end
            end
            SITYPE: begin
                ctrl.aluA    = srcA;
                ctrl.aluB    = ALUB_OP;
                ctrl.aluFunc = {2'b10, opcode[8:7]};  // Shift group
                ctrl.enF     = 1'b1;
                ctrl.sourceF = FSRC_ALU;
                ctrl         = applyDest(ctrl, dec.dest);
            end
            JTYPE: begin
                ctrl.aluA    = ALUA_PC;
                ctrl.aluB    = ALUB_ADDR;
                ctrl.aluFunc = ALU_JMP;
                ctrl.enPC    = 1'b1;
            end
            JFGINSTR: begin
                ctrl.aluA    = ALUA_PC;
                ctrl.aluB    = ALUB_OP;  // Relative offset
                ctrl.aluFunc = ALU_ADD;
                ctrl.enPC    = 1'b1;
            end
            PUSH1: begin
                ctrl.aluA      = srcA;
                ctrl.aluB      = ALUB_ZERO;
                ctrl.aluFunc   = ALU_ADD;
                ctrl.memAddr   = MEM_SP;
                ctrl.we        = 1'b1;
                ctrl.readStack = 1'b1;
            end
            PUSH2: begin
                ctrl.aluA    = ALUA_SP;
                ctrl.aluB    = ALUB_ONE;
                ctrl.aluFunc = ALU_SUB;  // SP - 1
                ctrl.enSP    = 1'b1;
            end
            POP1: begin
                ctrl.aluA      = ALUA_SP;
                ctrl.aluB      = ALUB_ONE;
                ctrl.aluFunc   = ALU_ADD;
                ctrl.enSP      = 1'b1;
                ctrl.memAddr   = MEM_ALU;  // Read at the new SP
                ctrl.re        = 1'b1;
                ctrl.readStack = 1'b1;
                ctrl.saveMem   = 1'b1;
            end
            POP2: begin
                ctrl.aluA    = ALUA_MEM;
                ctrl.aluB    = ALUB_ZERO;
                ctrl.aluFunc = ALU_ADD;
                if (dec.dest == DEST_ZERO) begin
                    ctrl.enF     = 1'b1;  // POP F
                    ctrl.sourceF = FSRC_ALUOUT;
                end else begin
                    ctrl = applyDest(ctrl, dec.dest);
                end
            end
            RIMMED: begin
                ctrl.memAddr = MEM_PC;
                ctrl.re      = 1'b1;
                ctrl.saveMem = 1'b1;
                ctrl         = incPc(ctrl);
            end
            RADDRESS: begin
                ctrl.memAddr = MEM_A;
                ctrl.re      = 1'b1;
                ctrl.saveMem = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== hdl/cpuController.sv ====
module cpuController
    import isaPkg::*, ctrlPkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic [opcodeW-1:0] opcode,  // Instruction register
    input  logic [flagsW-1:0]  flags,
    input  logic               stall,
    output ctrlWord_t          ctrl,
    output state_t             state    // Debug view of the FSM
);

    decoded_t dec;

    instrDecoder uInstrDecoder (
        .opcode (opcode),
        .flags  (flags),
        .dec    (dec)
    );

    stateSequencer uStateSequencer (
        .clk    (clk),
        .rst    (rst),
        .stall  (stall),
        .opcode (opcode),
        .dec    (dec),
        .state  (state)
    );

    controlDecoder uControlDecoder (
        .state  (state),
        .opcode (opcode),
        .dec    (dec),
        .ctrl   (ctrl)
    );

endmodule

// ==== testbench/cpuController_assert.sv ====
module cpuController_assert
    import ctrlPkg::*;
(
    input logic      clk,
    input logic      rst,
    input ctrlWord_t ctrl,
    input state_t    state
);

    timeunit 1ns;
    timeprecision 1ps;

    int failCount = 0;  // Number of failed assertions

    // One memory strobe per cycle
    assert property (@(posedge clk) !(ctrl.re && ctrl.we))
        else begin
            failCount++;
            $error("re and we are high in the same cycle");
        end

    assert property (@(posedge clk) rst |=> state == START)
        else begin
            failCount++;
            $error("state is not START during or right after reset");
        end

    assert property (@(posedge clk) disable iff (rst)
        state inside {START, FETCH, ATYPE, ITYPE, JTYPE, SITYPE, JFGINSTR,
                      PUSH1, PUSH2, POP1, POP2, RIMMED, RADDRESS, HALT})
        else begin
            failCount++;
            $error("state holds a code outside the supported set");
        end

endmodule

bind cpuController cpuController_assert uAssert (
    .clk   (clk),
    .rst   (rst),
    .ctrl  (ctrl),
    .state (state)
);

// ==== testbench/refModel.svh ====
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

// Main state of an instruction, HALT for encodings the controller does not support
function automatic state_t refMain(input logic [15:0] op, input logic [3:0] fl);
    logic [2:0] s1;
    logic [2:0] dst;
    logic       checksDst;
    logic       takesSrc;
    state_t     st;
    s1        = op[11:9];
    dst       = op[11:9];  // I type and POP write back through s1
    checksDst = 1'b0;
    takesSrc  = 1'b0;
    st        = HALT;
    if (op[15]) begin
        st = JTYPE;
    end else if (op[14]) begin
        st        = ITYPE;
        checksDst = 1'b1;
        takesSrc  = 1'b1;
    end else begin
        case (op[13:12])
            2'b00: begin
                st        = ATYPE;
                dst       = op[2:0];
                checksDst = 1'b1;
                takesSrc  = 1'b1;
            end
            2'b01: begin
                st        = SITYPE;
                dst       = op[6:4];
                checksDst = 1'b1;
                takesSrc  = 1'b1;
            end
            2'b10: begin
                if (op[11]) begin
                    st = FETCH;  // FLS/FLC
                end else begin
                    st = (fl[op[9:8]] == op[10]) ? JFGINSTR : FETCH;
                end
            end
            default: begin
                if (op[8:7] == 2'b00) begin
                    st       = PUSH1;
                    takesSrc = 1'b1;
                end else if (op[8:7] == 2'b01) begin
                    st        = POP1;
                    checksDst = 1'b1;
                end
            end
        endcase
    end
    if (checksDst && (dst == 3'd5 || dst == 3'd6)) begin
        st = HALT;
    end
    if (takesSrc && (s1 == 3'd5 || s1 == 3'd7)) begin
        st = HALT;
    end
    return st;
endfunction

function automatic state_t refNext(input state_t st, input logic [15:0] op,
                                   input logic [3:0] fl);
    state_t mainSt;
    logic   operandRead;
    mainSt      = refMain(op, fl);
    operandRead = (mainSt inside {ATYPE, ITYPE, SITYPE, PUSH1}) && op[11]
                  && !(mainSt == ITYPE && op[8] && op[13:12] == 2'b11);
    case (st)
        START:             return FETCH;
        FETCH: begin
            if (!operandRead) begin
                return mainSt;
            end
            return (op[10:9] == 2'b00) ? RIMMED : RADDRESS;  // Mode 4 or 6
        end
        RIMMED, RADDRESS:  return mainSt;
        PUSH1:             return PUSH2;
        POP1:              return POP2;
        ATYPE, ITYPE, SITYPE, JTYPE, JFGINSTR, PUSH2, POP2: return FETCH;
        default:           return HALT;
    endcase
endfunction

function automatic ctrlWord_t refCtrl(input state_t st, input logic [15:0] op,
                                      input logic [3:0] fl);
    ctrlWord_t  cw;
    logic [2:0] s1;
    logic [2:0] dst;
    aluASrc_t   src;
    logic [3:0] nf;
    logic       writesResult;
    cw           = '0;
    s1           = op[11:9];
    dst          = (st == ATYPE) ? op[2:0] : (st == SITYPE) ? op[6:4] : s1;
    src          = s1[2] ? ALUA_MEM : {2'b00, s1[1:0]};
    nf           = fl;
    writesResult = 1'b0;
    case (st)
        FETCH, RIMMED: begin
            cw.memAddr    = MEM_PC;
            cw.re         = 1'b1;
            cw.saveOpcode = (st == FETCH);
            cw.saveMem    = (st == RIMMED);
            cw.aluFunc    = ALU_ADD;  // PC + 1
            cw.aluA       = ALUA_PC;
            cw.aluB       = ALUB_ONE;
            cw.enPC       = 1'b1;
            if (st == FETCH && op[15:12] == 4'b0010 && op[11]) begin
                nf[op[9:8]] = op[10];
                cw.enF      = 1'b1;
                cw.sourceF  = FSRC_INSTR;
                cw.inF      = nf;
            end
        end
        RADDRESS: begin
            cw.memAddr = MEM_A;
            cw.re      = 1'b1;
            cw.saveMem = 1'b1;
        end
        ATYPE, ITYPE, SITYPE: begin
            cw.aluA = (st == ITYPE && s1 == 3'd0) ? ALUA_SP : src;
            cw.aluB = (st == ATYPE) ? {2'b00, op[4:3]} : ALUB_OP;
            if (st == ATYPE) begin
                cw.aluFunc = op[8:5];
            end else if (st == ITYPE) begin
                cw.aluFunc = {op[8], op[8], op[13:12]};
            end else begin
                cw.aluFunc = {2'b10, op[8:7]};
            end
            cw.enF       = 1'b1;
            cw.sourceF   = FSRC_ALU;
            cw.enSP      = (st == ITYPE && dst == 3'd0);
            writesResult = 1'b1;
        end
        JTYPE, JFGINSTR: begin
            cw.aluA    = ALUA_PC;
            cw.aluB    = (st == JTYPE) ? ALUB_ADDR : ALUB_OP;
            cw.aluFunc = (st == JTYPE) ? ALU_JMP : ALU_ADD;
            cw.enPC    = 1'b1;
        end
        PUSH1: begin
            cw.aluA      = src;
            cw.aluB      = ALUB_ZERO;
            cw.memAddr   = MEM_SP;
            cw.we        = 1'b1;
            cw.readStack = 1'b1;
        end
        PUSH2, POP1: begin
            cw.aluA    = ALUA_SP;
            cw.aluB    = ALUB_ONE;
            cw.aluFunc = (st == PUSH2) ? ALU_SUB : ALU_ADD;
            cw.enSP    = 1'b1;
            if (st == POP1) begin
                cw.memAddr   = MEM_ALU;
                cw.re        = 1'b1;
                cw.readStack = 1'b1;
                cw.saveMem   = 1'b1;
            end
        end
        POP2: begin
            cw.aluA      = ALUA_MEM;
            cw.aluB      = ALUB_ZERO;
            cw.enF       = (dst == 3'd0);  // POP into the flags
            cw.sourceF   = (dst == 3'd0) ? FSRC_ALUOUT : FSRC_ALU;
            writesResult = 1'b1;
        end
        default: begin
        end
    endcase
    if (writesResult) begin
        cw.enA = (dst == 3'd1);
        cw.enB = (dst == 3'd2);
        cw.enC = (dst == 3'd3);
        if (dst == 3'd4) begin
            cw.we      = 1'b1;  // Store at (A)
            cw.memAddr = MEM_A;
        end
    end
    return cw;
endfunction

`endif

// ==== testbench/tbCpuController.sv ====
module tbCpuController
    import isaPkg::*, ctrlPkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    logic               clk = 1'b0;
    logic               rst;
    logic [opcodeW-1:0] opcode;
    logic [flagsW-1:0]  flags;
    logic               stall;
    ctrlWord_t          ctrl;
    state_t             state;

    state_t expState;               // Model state for the coming cycle
    logic   modelValid  = 1'b0;
    logic   randomStall = 1'b0;
    string  testName    = "reset";
    int     errorCount  = 0;
    int     checkCount  = 0;

    cpuController dut (
        .clk    (clk),
        .rst    (rst),
        .opcode (opcode),
        .flags  (flags),
        .stall  (stall),
        .ctrl   (ctrl),
        .state  (state)
    );

    `include "refModel.svh"

    always #5 clk = ~clk;

    task automatic checkValue(input string what, input logic [63:0] expected,
                              input logic [63:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Mismatch %s %s: expected %0h, actual %0h",
                     testName, what, expected, actual);
        end
    endtask

    task automatic finishRun();
        int failures;
        failures = errorCount + dut.uAssert.failCount;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checkCount, errorCount, dut.uAssert.failCount);
        if (failures == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    endtask

    // Compared on the falling edge, halfway between input changes
    always @(negedge clk) begin
        if (modelValid) begin
            checkValue("state", 64'(expState), 64'(state));
            checkValue("ctrl", 64'(refCtrl(expState, opcode, flags)), 64'(ctrl));
        end
        if (rst) begin
            expState   = START;
            modelValid = 1'b1;
        end else if (!stall) begin
            expState = refNext(expState, opcode, flags);
        end
    end

    task automatic advance();
        @(posedge clk);
        stall <= randomStall && ($urandom_range(0, 3) == 0);
    endtask

    task automatic waitState(input state_t target);
        bit found;
        int i;
        found = 1'b0;
        for (i = 0; i < 20 && !found; i++) begin
            @(negedge clk);
            if (state == target) begin
                found = 1'b1;
            end else begin
                advance();
            end
        end
        if (!found) begin
            errorCount++;
            $display("Timeout in %s: state %s was never reached", testName, target.name());
            finishRun();
        end
    endtask

    // New instruction appears on the edge that enters FETCH
    task automatic issueInstr(input logic [opcodeW-1:0] op, input logic [flagsW-1:0] fl);
        bit found;
        int i;
        found = 1'b0;
        for (i = 0; i < 20 && !found; i++) begin
            @(negedge clk);
            found = !rst && !stall && refNext(state, opcode, flags) == FETCH;
            advance();
        end
        if (found) begin
            opcode <= op;
            flags  <= fl;
        end else begin
            errorCount++;
            $display("Timeout in %s: state FETCH was never reached", testName);
            finishRun();
        end
    endtask

    task automatic applyReset();
        @(posedge clk);
        rst   <= 1'b1;
        stall <= 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    endtask

    function automatic logic [2:0] pickMode();  // Register, immediate or (A)
        int unsigned r;
        r = $urandom_range(0, 5);
        return (r == 5) ? 3'd6 : 3'(r);
    endfunction

    function automatic logic [2:0] pickDest();
        return 3'($urandom_range(0, 4));
    endfunction

    // Kinds 0 to 6 are A, I, SI, J, F, PUSH and POP
    function automatic logic [15:0] randomOp(input int kind);
        case (kind)
            0:       return {4'b0000, pickMode(), 4'($urandom), 2'($urandom), pickDest()};
            1:       return {2'b01, 2'($urandom), pickDest(), 9'($urandom)};
            2:       return {4'b0001, pickMode(), 2'($urandom), pickDest(), 4'($urandom)};
            3:       return {1'b1, 15'($urandom)};
            4:       return {4'b0010, 12'($urandom)};
            5:       return {4'b0011, pickMode(), 2'b00, 7'($urandom)};
            default: return {4'b0011, pickDest(), 2'b01, 7'($urandom)};
        endcase
    endfunction

    function automatic logic [15:0] badOpcode(input int k);
        case (k)
            0:       return {4'b0000, 3'd5, 9'($urandom)};           // A type with s1 5
            1:       return {4'b0001, 3'd7, 9'($urandom)};           // SI type with s1 7
            2:       return {4'b0000, 3'd1, 6'($urandom), 3'd5};     // A type with dest 5
            3:       return {4'b0001, 3'd0, 2'($urandom), 3'd6, 4'($urandom)};
            4:       return {4'b0011, 3'd1, 2'b10, 7'($urandom)};    // SVPC
            5:       return {4'b0011, 3'd1, 2'b11, 7'($urandom)};    // RET
            6:       return {4'b0011, 3'd6, 2'b01, 7'($urandom)};    // POP with dest 6
            default: return {4'b0110, 3'd5, 9'($urandom)};           // I type with s1 5
        endcase
    endfunction

    initial begin
        int n;
        void'($urandom(63732));
        rst    = 1'b1;
        opcode = '0;
        flags  = '0;
        stall  = 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        checkValue("reset state", 64'(START), 64'(state));
        checkValue("reset ctrl", 64'(0), 64'(ctrl));
        waitState(FETCH);
        checkValue("fetch re", 64'(1), 64'(ctrl.re));
        checkValue("fetch saveOpcode", 64'(1), 64'(ctrl.saveOpcode));
        checkValue("fetch enPC", 64'(1), 64'(ctrl.enPC));

        testName = "alu";
        for (n = 0; n < 60; n++) begin
            issueInstr(randomOp($urandom_range(0, 2)), 4'($urandom));
        end

        testName = "flag";
        issueInstr({4'b0010, 1'b1, 1'b1, 2'd2, 8'd0}, 4'b0000);  // FLS on flag 2
        @(negedge clk);
        checkValue("fls enF", 64'(1), 64'(ctrl.enF));
        checkValue("fls inF", 64'(4'b0100), 64'(ctrl.inF));
        issueInstr({4'b0010, 1'b0, 1'b1, 2'd1, 8'h05}, 4'b0010);  // JFS taken on flag 1
        waitState(JFGINSTR);
        for (n = 0; n < 40; n++) begin
            issueInstr(randomOp($urandom_range(3, 4)), 4'($urandom));
        end

        testName = "stack";
        issueInstr({4'b0011, 3'd0, 2'b01, 7'd0}, 4'($urandom));   // POP into flags
        waitState(POP2);
        checkValue("pop enF", 64'(1), 64'(ctrl.enF));
        checkValue("pop sourceF", 64'(FSRC_ALUOUT), 64'(ctrl.sourceF));
        for (n = 0; n < 30; n++) begin
            issueInstr(randomOp($urandom_range(5, 6)), 4'($urandom));
        end

        testName    = "stall";
        randomStall = 1'b1;
        for (n = 0; n < 50; n++) begin
            issueInstr(randomOp($urandom_range(0, 6)), 4'($urandom));
        end
        randomStall = 1'b0;

        testName = "halt";
        for (n = 0; n < 8; n++) begin
            issueInstr(badOpcode(n), 4'($urandom));
            waitState(HALT);
            repeat (3) advance();  // HALT must hold
            applyReset();
        end

        testName = "end";
        issueInstr(randomOp(0), 4'($urandom));
        repeat (4) advance();
        finishRun();
    end

endmodule

// ==== files.f ====
+incdir+testbench
hdl/isaPkg.sv
hdl/ctrlPkg.sv
hdl/instrDecoder.sv
hdl/stateSequencer.sv
hdl/controlDecoder.sv
hdl/cpuController.sv
testbench/cpuController_assert.sv
testbench/tbCpuController.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tbCpuController \
    --Mdir obj_dir -o simCpuController

./obj_dir/simCpuController +verilator+error+limit+100 | tee sim.log

if grep -q "=== PASS ===" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
